// File: Bender.yml
package:
  name: ntt_butterfly_2x2

export_include_dirs:
  - include

sources:
  # Packages first, then the datapath from the leaves up
  - include_dirs:
      - include
    files:
      - src/ntt_mode_pkg.sv
      - src/ntt_data_pkg.sv
      - src/ntt_mod_mult.sv
      - src/ntt_butterfly.sv
      - src/ntt_twiddle_delay.sv
      - src/ntt_ready_ctrl.sv
      - src/ntt_butterfly_2x2.sv

  - target: test
    include_dirs:
      - include
    files:
      - test/ntt_butterfly_2x2_props.sv
      - test/tb_ntt_butterfly_2x2.sv

// File: include/ntt_macros.svh
/*
 * Coefficient width, ML-DSA modulus and pipeline latencies
 * for the 2x2 NTT butterfly block
 */

`ifndef NTT_MACROS_SVH
`define NTT_MACROS_SVH

// Coefficient width in bits
`define NTT_COEFF_WIDTH 23

// ML-DSA prime q = 2^23 - 2^13 + 1
`define NTT_Q 8380417

// Product register plus reduction register
`define NTT_MULT_LATENCY 2

// One butterfly unit, identical for every mode
`define NTT_BF_LATENCY 3

// Two butterfly stages back to back
`define NTT_2X2_LATENCY 6

`endif

// File: src/ntt_butterfly.sv
/*
 * Single butterfly unit for ct, gs, pwm, pwa and pws,
 * three cycles in every mode
 */

`timescale 1ns/1ps
`default_nettype none

`include "ntt_macros.svh"

module ntt_butterfly (
    input  wire                      clk,
    input  wire                      reset_n,
    input  wire                      zeroize_i,
    input  var ntt_mode_pkg::mode_t  mode_i,
    input  var ntt_data_pkg::coeff_t u_i,
    input  var ntt_data_pkg::coeff_t v_i,
    input  var ntt_data_pkg::coeff_t w_i,
    output ntt_data_pkg::coeff_t     u_o,
    output ntt_data_pkg::coeff_t     v_o
);

    localparam int W  = `NTT_COEFF_WIDTH;
    localparam int ML = `NTT_MULT_LATENCY;

    localparam logic [W:0] Q = `NTT_Q;

    logic ct_mode;
    logic gs_mode;
    logic pwm_mode;

    ntt_data_pkg::coeff_t          pass_val;
    ntt_data_pkg::coeff_t [ML-1:0] pass_sr;
    ntt_data_pkg::coeff_t          diff_r;
    ntt_data_pkg::coeff_t          w_r;
    ntt_data_pkg::coeff_t          mul_a;
    ntt_data_pkg::coeff_t          mul_b;
    ntt_data_pkg::coeff_t          mul_p;
    ntt_data_pkg::coeff_t          u_r;
    ntt_data_pkg::coeff_t          v_r;

    //----------------------------------------
    // Modular add and subtract
    //----------------------------------------
    function automatic ntt_data_pkg::coeff_t mod_add(ntt_data_pkg::coeff_t a,
                                                     ntt_data_pkg::coeff_t b);
        logic [W:0] s;
        s = a + b;
        if (s >= Q) begin
            s = s - Q;
        end
        return s[W-1:0];
    endfunction

    function automatic ntt_data_pkg::coeff_t mod_sub(ntt_data_pkg::coeff_t a,
                                                     ntt_data_pkg::coeff_t b);
        logic [W:0] d;
        if (a >= b) begin
            d = a - b;
        end
        else begin
            d = a + Q - b;
        end
        return d[W-1:0];
    endfunction

    assign ct_mode  = (mode_i == ntt_mode_pkg::ct);
    assign gs_mode  = (mode_i == ntt_mode_pkg::gs);
    assign pwm_mode = (mode_i == ntt_mode_pkg::pwm);

    // Value that bypasses the multiplier is u for ct and the sum or difference otherwise
    always_comb begin
        case (mode_i)
            ntt_mode_pkg::ct:  pass_val = u_i;
            ntt_mode_pkg::pws: pass_val = mod_sub(u_i, v_i);
            default:           pass_val = mod_add(u_i, v_i);
        endcase
    end

    // gs multiplies the registered difference one cycle later than ct
    always_comb begin
        if (gs_mode) begin
            mul_a = diff_r;
            mul_b = w_r;
        end
        else if (ct_mode) begin
            mul_a = w_i;
            mul_b = v_i;
        end
        else begin
            mul_a = u_i;
            mul_b = v_i;
        end
    end

    ntt_mod_mult u_mult (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .a_i       (mul_a),
        .b_i       (mul_b),
        .p_o       (mul_p)
    );

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pass_sr <= '0;
            diff_r  <= '0;
            w_r     <= '0;
            u_r     <= '0;
            v_r     <= '0;
        end
        else if (zeroize_i) begin
            pass_sr <= '0;
            diff_r  <= '0;
            w_r     <= '0;
            u_r     <= '0;
            v_r     <= '0;
        end
        else begin
            // Bypass line is as deep as the multiplier
            pass_sr <= {pass_sr[ML-2:0], pass_val};
            diff_r  <= mod_sub(u_i, v_i);
            w_r     <= w_i;
            if (ct_mode) begin
                u_r <= mod_add(pass_sr[ML-1], mul_p);
                v_r <= mod_sub(pass_sr[ML-1], mul_p);
            end
            else if (pwm_mode) begin
                u_r <= mul_p;
                v_r <= '0;
            end
            else begin
                u_r <= pass_sr[ML-1];
                v_r <= '0;
            end
        end
    end

    assign u_o = u_r;
    // gs product leaves the multiplier in cycle 3 already
    assign v_o = gs_mode ? mul_p : v_r;

endmodule

`default_nettype wire

// File: src/ntt_butterfly_2x2.sv
/*
 * 2x2 NTT butterfly block, two stages of two butterflies,
 * or four parallel pointwise lanes
 */

`timescale 1ns/1ps
`default_nettype none

module ntt_butterfly_2x2 (
    input  wire                        clk,
    input  wire                        reset_n,
    input  wire                        zeroize_i,
    input  var ntt_mode_pkg::mode_t    mode_i,
    input  wire                        enable_i,
    input  var ntt_data_pkg::operand_u operands_i,
    output ntt_data_pkg::result_u      results_o,
    output logic                       ready_o
);

    logic pwo_mode;

    // First-stage inputs
    ntt_data_pkg::coeff_t u00, v00, u01, v01;
    // Second-stage inputs
    ntt_data_pkg::coeff_t u10, v10, u11, v11;
    // First-stage outputs a, b, c, d
    ntt_data_pkg::coeff_t s1_u0, s1_v0, s1_u1, s1_v1;
    ntt_data_pkg::coeff_t w10_d, w11_d;
    // Second-stage outputs
    ntt_data_pkg::coeff_t u20, v20, u21, v21;

    assign pwo_mode = (mode_i inside {ntt_mode_pkg::pwm, ntt_mode_pkg::pwa,
                                      ntt_mode_pkg::pws});

    //----------------------------------------
    // Operand decode
    //----------------------------------------
    always_comb begin
        // Lane u0 and u1 occupy the same bits as u00 and u01
        u00 = operands_i.bf.u00;
        u01 = operands_i.bf.u01;
        if (pwo_mode) begin
            v00 = operands_i.pw.v0;
            v01 = operands_i.pw.v1;
            // Lanes 2 and 3 enter the second stage directly
            u10 = operands_i.pw.u2;
            v10 = operands_i.pw.v2;
            u11 = operands_i.pw.u3;
            v11 = operands_i.pw.v3;
        end
        else begin
            v00 = operands_i.bf.v00;
            v01 = operands_i.bf.v01;
            u10 = s1_u0;
            v10 = s1_u1;
            u11 = s1_v0;
            v11 = s1_v1;
        end
    end

    //----------------------------------------
    // First stage
    //----------------------------------------
    ntt_butterfly u_bf00 (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i), .mode_i(mode_i),
        .u_i(u00), .v_i(v00), .w_i(operands_i.bf.w00),
        .u_o(s1_u0), .v_o(s1_v0)
    );

    ntt_butterfly u_bf01 (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i), .mode_i(mode_i),
        .u_i(u01), .v_i(v01), .w_i(operands_i.bf.w01),
        .u_o(s1_u1), .v_o(s1_v1)
    );

    ntt_twiddle_delay u_tw_delay (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .w10_i     (operands_i.bf.w10),
        .w11_i     (operands_i.bf.w11),
        .w10_o     (w10_d),
        .w11_o     (w11_d)
    );

    //----------------------------------------
    // Second stage
    //----------------------------------------
    ntt_butterfly u_bf10 (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i), .mode_i(mode_i),
        .u_i(u10), .v_i(v10), .w_i(w10_d),
        .u_o(u20), .v_o(v20)
    );

    ntt_butterfly u_bf11 (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i), .mode_i(mode_i),
        .u_i(u11), .v_i(v11), .w_i(w11_d),
        .u_o(u21), .v_o(v21)
    );

    // Pointwise results all leave on the u outputs
    always_comb begin
        if (pwo_mode) begin
            results_o.pw.uv0 = s1_u0;
            results_o.pw.uv1 = s1_u1;
            results_o.pw.uv2 = u20;
            results_o.pw.uv3 = u21;
        end
        else begin
            results_o.bf.u20 = u20;
            results_o.bf.v20 = v20;
            results_o.bf.u21 = u21;
            results_o.bf.v21 = v21;
        end
    end

    ntt_ready_ctrl u_ready (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .mode_i    (mode_i),
        .enable_i  (enable_i),
        .ready_o   (ready_o)
    );

endmodule

`default_nettype wire

// File: src/ntt_data_pkg.sv
/*
 * Coefficient type, operand and result words of the 2x2 butterfly,
 * each readable as butterfly or pointwise data
 */

`default_nettype none

`include "ntt_macros.svh"

package ntt_data_pkg;

    // Always held below q
    typedef logic [`NTT_COEFF_WIDTH-1:0] coeff_t;

    //----------------------------------------
    // Operand word, 8 coefficients
    //----------------------------------------
    typedef struct packed {
        coeff_t u00, u01;
        coeff_t v00, v01;
        coeff_t w00, w01;
        coeff_t w10, w11;
    } bf_uvw_t;

    typedef struct packed {
        coeff_t u0, u1, u2, u3;
        coeff_t v0, v1, v2, v3;
    } pwo_uv_t;

    // bf in ct and gs, pw in the pointwise modes
    typedef union packed {
        bf_uvw_t bf;
        pwo_uv_t pw;
    } operand_u;

    //----------------------------------------
    // Result word, 4 coefficients
    //----------------------------------------
    typedef struct packed {
        coeff_t u20, v20;
        coeff_t u21, v21;
    } bf_uvo_t;

    typedef struct packed {
        coeff_t uv0, uv1, uv2, uv3;
    } pwo_res_t;

    typedef union packed {
        bf_uvo_t  bf;
        pwo_res_t pw;
    } result_u;

endpackage

`default_nettype wire

// File: src/ntt_mod_mult.sv
/*
 * Pipelined modular multiplier, full product then reduction mod q
 */

`timescale 1ns/1ps
`default_nettype none

`include "ntt_macros.svh"

module ntt_mod_mult (
    input  wire                  clk,
    input  wire                  reset_n,
    input  wire                  zeroize_i,
    input  var ntt_data_pkg::coeff_t a_i,
    input  var ntt_data_pkg::coeff_t b_i,
    output ntt_data_pkg::coeff_t     p_o
);

    localparam int W  = `NTT_COEFF_WIDTH;
    localparam int PW = 2 * W;

    localparam logic [PW-1:0] Q = `NTT_Q;

    logic [PW-1:0]         prod_r;
    logic [PW-1:0]         prod_rem;
    ntt_data_pkg::coeff_t  p_r;

    // Remainder is always below q, so it fits one coefficient
    assign prod_rem = prod_r % Q;

    // Cycle 1 holds the raw 46-bit product, cycle 2 the reduced value
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_r <= '0;
            p_r    <= '0;
        end
        else if (zeroize_i) begin
            prod_r <= '0;
            p_r    <= '0;
        end
        else begin
            prod_r <= a_i * b_i;
            p_r    <= prod_rem[W-1:0];
        end
    end

    assign p_o = p_r;

endmodule

`default_nettype wire

// File: src/ntt_mode_pkg.sv
/*
 * Operating modes of the NTT butterfly block
 */

`default_nettype none

package ntt_mode_pkg;

    // ct and gs run the 2x2 butterfly network
    // pwm, pwa and pws run four independent pointwise lanes
    typedef enum logic [2:0] {
        ct  = 3'd0,
        gs  = 3'd1,
        pwm = 3'd2,
        pwa = 3'd3,
        pws = 3'd4
    } mode_t;

endpackage

`default_nettype wire

// File: src/ntt_ready_ctrl.sv
/*
 * Enable shift register with a mode-dependent ready tap
 */

`timescale 1ns/1ps
`default_nettype none

`include "ntt_macros.svh"

module ntt_ready_ctrl (
    input  wire                     clk,
    input  wire                     reset_n,
    input  wire                     zeroize_i,
    input  var ntt_mode_pkg::mode_t mode_i,
    input  wire                     enable_i,
    output logic                    ready_o
);

    localparam int LONG_TAP  = `NTT_2X2_LATENCY;
    localparam int SHORT_TAP = `NTT_BF_LATENCY;

    logic [LONG_TAP-1:0] en_sr;
    logic                pwo_mode;

    assign pwo_mode = (mode_i inside {ntt_mode_pkg::pwm, ntt_mode_pkg::pwa,
                                      ntt_mode_pkg::pws});

    // Bit k holds the enable from k+1 cycles ago
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            en_sr <= '0;
        end
        else if (zeroize_i) begin
            en_sr <= '0;
        end
        else begin
            en_sr <= {en_sr[LONG_TAP-2:0], enable_i};
        end
    end

    // Pointwise results skip the second stage
    assign ready_o = pwo_mode ? en_sr[SHORT_TAP-1] : en_sr[LONG_TAP-1];

endmodule

`default_nettype wire

// File: src/ntt_twiddle_delay.sv
/*
 * Delay line for the second-stage twiddles w10 and w11
 */

`timescale 1ns/1ps
`default_nettype none

`include "ntt_macros.svh"

module ntt_twiddle_delay (
    input  wire                      clk,
    input  wire                      reset_n,
    input  wire                      zeroize_i,
    input  var ntt_data_pkg::coeff_t w10_i,
    input  var ntt_data_pkg::coeff_t w11_i,
    output ntt_data_pkg::coeff_t     w10_o,
    output ntt_data_pkg::coeff_t     w11_o
);

    // Matches the first-stage butterfly latency
    localparam int DEPTH = `NTT_BF_LATENCY;

    ntt_data_pkg::coeff_t [DEPTH-1:0] w10_sr;
    ntt_data_pkg::coeff_t [DEPTH-1:0] w11_sr;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            w10_sr <= '0;
            w11_sr <= '0;
        end
        else if (zeroize_i) begin
            w10_sr <= '0;
            w11_sr <= '0;
        end
        else begin
            w10_sr <= {w10_sr[DEPTH-2:0], w10_i};
            w11_sr <= {w11_sr[DEPTH-2:0], w11_i};
        end
    end

    assign w10_o = w10_sr[DEPTH-1];
    assign w11_o = w11_sr[DEPTH-1];

endmodule

`default_nettype wire

// File: tb.f
+incdir+include
src/ntt_mode_pkg.sv
src/ntt_data_pkg.sv
src/ntt_mod_mult.sv
src/ntt_butterfly.sv
src/ntt_twiddle_delay.sv
src/ntt_ready_ctrl.sv
src/ntt_butterfly_2x2.sv
test/ntt_butterfly_2x2_props.sv
test/tb_ntt_butterfly_2x2.sv

// File: test/ntt_butterfly_2x2_props.sv
/*
 * Concurrent assertions on ready timing and result range
 * of the 2x2 butterfly top level
 */

`timescale 1ns/1ps
`default_nettype none

`include "ntt_macros.svh"

module ntt_butterfly_2x2_props (
    input wire                       clk,
    input wire                       reset_n,
    input var ntt_mode_pkg::mode_t   mode_i,
    input wire                       enable_i,
    input var ntt_data_pkg::result_u results_i,
    input wire                       ready_i
);

    localparam logic [`NTT_COEFF_WIDTH-1:0] Q = `NTT_Q;

    int unsigned fail_count = 0;
    logic        bf_mode;

    assign bf_mode = (mode_i == ntt_mode_pkg::ct) || (mode_i == ntt_mode_pkg::gs);

    a_ready_in_reset: assert property (@(posedge clk) !reset_n |-> !ready_i)
    else begin
        $error("ready_o high while reset_n is low");
        fail_count++;
    end

    a_bf_latency: assert property (@(posedge clk) disable iff (!reset_n)
        (ready_i && bf_mode) |-> $past(enable_i, `NTT_2X2_LATENCY))
    else begin
        $error("ready_o in ct or gs without enable 6 cycles earlier");
        fail_count++;
    end

    a_pwo_latency: assert property (@(posedge clk) disable iff (!reset_n)
        (ready_i && !bf_mode) |-> $past(enable_i, `NTT_BF_LATENCY))
    else begin
        $error("ready_o in pointwise mode without enable 3 cycles earlier");
        fail_count++;
    end

    // The bf view covers the same four coefficients as the pw view
    a_result_range: assert property (@(posedge clk) disable iff (!reset_n)
        ready_i |-> (results_i.bf.u20 < Q) && (results_i.bf.v20 < Q) &&
                    (results_i.bf.u21 < Q) && (results_i.bf.v21 < Q))
    else begin
        $error("result coefficient not below q");
        fail_count++;
    end

endmodule

`default_nettype wire

// File: test/tb_ntt_butterfly_2x2.sv
/*
 * Testbench for the 2x2 NTT butterfly block with random traffic in every mode,
 * a reference model, and zeroize and reset checks
 */

`timescale 1ns/1ps
`default_nettype none

`include "ntt_macros.svh"

module tb_ntt_butterfly_2x2;

    localparam int              W            = `NTT_COEFF_WIDTH;
    localparam longint unsigned QL           = `NTT_Q;
    localparam int              IDLE_TIMEOUT = 200;

    logic                   clk = 1'b0;
    logic                   reset_n;
    logic                   zeroize_i;
    ntt_mode_pkg::mode_t    mode_i;
    logic                   enable_i;
    ntt_data_pkg::operand_u operands_i;
    ntt_data_pkg::result_u  results_o;
    logic                   ready_o;

    integer seed;
    int     cyc;
    int     errors;
    int     checks;
    int     tests;
    bit     aborted;

    // Expected result words in arrival order, each with its due cycle
    int                    due_q[$];
    ntt_data_pkg::result_u exp_q[$];

    string bf_names[4] = '{"u20", "v20", "u21", "v21"};
    string pw_names[4] = '{"uv0", "uv1", "uv2", "uv3"};

    ntt_butterfly_2x2 u_dut (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize_i  (zeroize_i),
        .mode_i     (mode_i),
        .enable_i   (enable_i),
        .operands_i (operands_i),
        .results_o  (results_o),
        .ready_o    (ready_o)
    );

    bind ntt_butterfly_2x2 ntt_butterfly_2x2_props u_props (
        .clk       (clk),
        .reset_n   (reset_n),
        .mode_i    (mode_i),
        .enable_i  (enable_i),
        .results_i (results_o),
        .ready_i   (ready_o)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    //----------------------------------------
    // Reference model
    //----------------------------------------
    function automatic ntt_data_pkg::coeff_t add_q(input ntt_data_pkg::coeff_t a,
                                                   input ntt_data_pkg::coeff_t b);
        longint unsigned s;
        s = a;
        s = (s + b) % QL;
        return s[W-1:0];
    endfunction

    function automatic ntt_data_pkg::coeff_t sub_q(input ntt_data_pkg::coeff_t a,
                                                   input ntt_data_pkg::coeff_t b);
        longint unsigned s;
        s = a;
        s = (s + QL - b) % QL;
        return s[W-1:0];
    endfunction

    function automatic ntt_data_pkg::coeff_t mul_q(input ntt_data_pkg::coeff_t a,
                                                   input ntt_data_pkg::coeff_t b);
        longint unsigned s;
        s = a;
        s = (s * b) % QL;
        return s[W-1:0];
    endfunction

    function automatic ntt_data_pkg::coeff_t lane_result(input ntt_mode_pkg::mode_t m,
                                                         input ntt_data_pkg::coeff_t u,
                                                         input ntt_data_pkg::coeff_t v);
        case (m)
            ntt_mode_pkg::pwm: return mul_q(u, v);
            ntt_mode_pkg::pwa: return add_q(u, v);
            default:           return sub_q(u, v);
        endcase
    endfunction

    function automatic ntt_data_pkg::result_u model_result(input ntt_mode_pkg::mode_t m,
                                                           input ntt_data_pkg::operand_u op);
        ntt_data_pkg::coeff_t  a, b, c, d;
        ntt_data_pkg::result_u r;
        r = '0;
        case (m)
            ntt_mode_pkg::ct: begin
                a = add_q(op.bf.u00, mul_q(op.bf.w00, op.bf.v00));
                b = sub_q(op.bf.u00, mul_q(op.bf.w00, op.bf.v00));
                c = add_q(op.bf.u01, mul_q(op.bf.w01, op.bf.v01));
                d = sub_q(op.bf.u01, mul_q(op.bf.w01, op.bf.v01));
                r.bf.u20 = add_q(a, mul_q(op.bf.w10, c));
                r.bf.v20 = sub_q(a, mul_q(op.bf.w10, c));
                r.bf.u21 = add_q(b, mul_q(op.bf.w11, d));
                r.bf.v21 = sub_q(b, mul_q(op.bf.w11, d));
            end
            ntt_mode_pkg::gs: begin
                a = add_q(op.bf.u00, op.bf.v00);
                b = mul_q(sub_q(op.bf.u00, op.bf.v00), op.bf.w00);
                c = add_q(op.bf.u01, op.bf.v01);
                d = mul_q(sub_q(op.bf.u01, op.bf.v01), op.bf.w01);
                r.bf.u20 = add_q(a, c);
                r.bf.v20 = mul_q(sub_q(a, c), op.bf.w10);
                r.bf.u21 = add_q(b, d);
                r.bf.v21 = mul_q(sub_q(b, d), op.bf.w11);
            end
            default: begin
                r.pw.uv0 = lane_result(m, op.pw.u0, op.pw.v0);
                r.pw.uv1 = lane_result(m, op.pw.u1, op.pw.v1);
                r.pw.uv2 = lane_result(m, op.pw.u2, op.pw.v2);
                r.pw.uv3 = lane_result(m, op.pw.u3, op.pw.v3);
            end
        endcase
        return r;
    endfunction

    function automatic int latency_of(input ntt_mode_pkg::mode_t m);
        if (m == ntt_mode_pkg::ct || m == ntt_mode_pkg::gs) begin
            return `NTT_2X2_LATENCY;
        end
        return `NTT_BF_LATENCY;
    endfunction

    //----------------------------------------
    // Stimulus helpers
    //----------------------------------------
    // Edge mode mixes in 0 and q-1
    function automatic ntt_data_pkg::coeff_t rand_coeff(input bit edges);
        int unsigned     r;
        longint unsigned v;
        r = $random(seed);
        v = r % QL;
        if (edges) begin
            case ($unsigned($random(seed)) % 4)
                0:       v = 0;
                1:       v = QL - 1;
                default: ;
            endcase
        end
        return v[W-1:0];
    endfunction

    function automatic ntt_data_pkg::operand_u random_word(input bit edges);
        logic [8*W-1:0]         raw;
        ntt_data_pkg::operand_u op;
        for (int i = 0; i < 8; i++) begin
            raw[i*W +: W] = rand_coeff(edges);
        end
        op = raw;
        return op;
    endfunction

    task automatic check_value(input string name, input logic [95:0] got,
                               input logic [95:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED t=%0t %s: got %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    // Sample at the falling edge, where DUT outputs and driven inputs are stable
    always @(negedge clk) begin : monitor
        logic [4*W-1:0] got;
        logic [4*W-1:0] exp;
        bit             expect_ready;
        bit             is_bf;
        cyc++;
        if (!reset_n) begin
            check_value("ready_o", ready_o, 1'b0);
            due_q.delete();
            exp_q.delete();
        end
        else begin
            expect_ready = (due_q.size() != 0) && (due_q[0] == cyc);
            is_bf = (mode_i == ntt_mode_pkg::ct) || (mode_i == ntt_mode_pkg::gs);
            check_value("ready_o", ready_o, expect_ready);
            if (expect_ready) begin
                got = results_o;
                exp = exp_q.pop_front();
                void'(due_q.pop_front());
                for (int i = 0; i < 4 && ready_o; i++) begin
                    check_value($sformatf("results_o.%s", is_bf ? bf_names[i] : pw_names[i]),
                                got[(3-i)*W +: W], exp[(3-i)*W +: W]);
                end
            end
            // Zeroize drops every word in flight, including one enabled now
            if (zeroize_i) begin
                due_q.delete();
                exp_q.delete();
            end
            else if (enable_i) begin
                due_q.push_back(cyc + latency_of(mode_i));
                exp_q.push_back(model_result(mode_i, operands_i));
            end
        end
    end

    task automatic wait_idle();
        int n;
        n = 0;
        while (!aborted && due_q.size() != 0) begin
            @(posedge clk);
            n++;
            if (n >= IDLE_TIMEOUT) begin
                $display("Timeout: %0d results still outstanding after %0d cycles",
                         due_q.size(), n);
                aborted = 1'b1;
            end
        end
        // Enable shift line keeps old bits past the short tap
        repeat (`NTT_2X2_LATENCY) @(posedge clk);
    endtask

    task automatic select_mode(input ntt_mode_pkg::mode_t m);
        wait_idle();
        @(posedge clk);
        mode_i <= m;
    endtask

    task automatic drive_words(input int count, input int max_gap, input bit edges);
        int gap;
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            enable_i   <= 1'b1;
            operands_i <= random_word(edges);
            gap = (max_gap > 0) ? ($unsigned($random(seed)) % (max_gap + 1)) : 0;
            repeat (gap) begin
                @(posedge clk);
                enable_i <= 1'b0;
            end
        end
        @(posedge clk);
        enable_i <= 1'b0;
    endtask

    task automatic report_test(input string name, input int words, input int start_errors);
        tests++;
        $display("%-8s %3d words, %0d errors", name, words, errors - start_errors);
    endtask

    //----------------------------------------
    // Tests
    //----------------------------------------
    task automatic traffic_test(input ntt_mode_pkg::mode_t m, input string name,
                                input int count, input int max_gap, input bit edges);
        int start;
        start = errors;
        select_mode(m);
        drive_words(count, max_gap, edges);
        wait_idle();
        report_test(name, count, start);
    endtask

    task automatic zeroize_test();
        int start;
        start = errors;
        select_mode(ntt_mode_pkg::ct);
        drive_words(4, 0, 1'b0);
        @(posedge clk);
        zeroize_i <= 1'b1;
        @(posedge clk);
        zeroize_i <= 1'b0;
        @(negedge clk);
        check_value("results_o", results_o, '0);
        // Any ready here has no enable behind it
        repeat (2 * `NTT_2X2_LATENCY) @(posedge clk);
        drive_words(1, 0, 1'b0);
        wait_idle();
        report_test("zeroize", 5, start);
    endtask

    task automatic reset_test();
        int start;
        start = errors;
        drive_words(3, 0, 1'b0);
        reset_n <= 1'b0;
        repeat (4) @(posedge clk);
        reset_n <= 1'b1;
        repeat (2 * `NTT_2X2_LATENCY) @(posedge clk);
        drive_words(1, 0, 1'b0);
        wait_idle();
        report_test("reset", 4, start);
    endtask

    initial begin : main
        int prop_fails;
        seed       = 92;
        cyc        = 0;
        errors     = 0;
        checks     = 0;
        tests      = 0;
        aborted    = 1'b0;
        reset_n    = 1'b0;
        zeroize_i  = 1'b0;
        mode_i     = ntt_mode_pkg::ct;
        enable_i   = 1'b0;
        operands_i = '0;
        repeat (4) @(posedge clk);
        reset_n <= 1'b1;

        traffic_test(ntt_mode_pkg::ct,  "ct 2x2", 40, 0, 1'b0);
        traffic_test(ntt_mode_pkg::gs,  "gs 2x2", 40, 0, 1'b0);
        traffic_test(ntt_mode_pkg::pwm, "pwm",    40, 3, 1'b0);
        traffic_test(ntt_mode_pkg::pwa, "pwa",    40, 2, 1'b1);
        traffic_test(ntt_mode_pkg::pws, "pws",    40, 2, 1'b1);
        zeroize_test();
        reset_test();

        prop_fails = u_dut.u_props.fail_count;
        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests, checks, errors, prop_fails);
        if (errors == 0 && prop_fails == 0 && !aborted) begin
            $display("Simulation passed");
        end
        else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
